//--- verilog/gayle_ide_config.svh
/*
 * Sizing for the Gayle IDE bridge.
 * Sector buffer geometry and the CPU address fields used by the decoder.
 */
`ifndef GAYLE_IDE_CONFIG_SVH
`define GAYLE_IDE_CONFIG_SVH

// one sector of 512 bytes held as 16-bit words
`define IDE_FIFO_AW    8
`define IDE_FIFO_DEPTH 256

// cpu word address, bits 23 down to 1
`define IDE_ADDR_W     23
// window nibble and task file index inside the address
`define IDE_WIN_MSB    15
`define IDE_WIN_LSB    12
`define IDE_REG_MSB    4
`define IDE_REG_LSB    2

`endif

//--- verilog/gayle_ide_pkg.sv
/*
 * Types shared by the Gayle IDE blocks.
 * Task file index, ATA status byte and the host status command.
 */
`default_nettype none

package gayle_ide_pkg;

	// task file register index, cpu address bits 4:2
	typedef enum logic [2:0] {
		REG_DATA    = 3'd0,
		REG_ERROR   = 3'd1,
		REG_SECCNT  = 3'd2,
		REG_SECNUM  = 3'd3,
		REG_CYLLO   = 3'd4,
		REG_CYLHI   = 3'd5,
		REG_DEVHEAD = 3'd6,
		REG_STATUS  = 3'd7
	} ide_reg_e;

	// ata status byte as seen by the cpu
	typedef struct packed {
		logic       bsy;
		logic       drdy;
		logic [1:0] rsvd_hi;
		logic       drq;
		logic [1:0] rsvd_lo;
		logic       err;
	} ide_status_t;

	// host status command, low byte of hdd_data_out
	typedef struct packed {
		logic       done;
		logic [1:0] rsvd_hi;
		logic       intrq;
		logic       pio_in;
		logic       pio_out;
		logic       rsvd_lo;
		logic       error;
	} host_status_t;

endpackage

`default_nettype wire

//--- verilog/ide_sel_if.sv
/*
 * Decoded CPU register selects and bus strobes.
 * The decoder drives it, the task file, command and read blocks consume it.
 */
`default_nettype none

interface ide_sel_if
	import gayle_ide_pkg::*;
();
	logic        sel_tfr;
	logic        sel_fifo;
	logic        sel_status;
	logic        sel_command;
	logic        sel_intreq;
	logic        sel_intena;
	logic        sel_gayleid;
	ide_reg_e    tfr_index;
	logic        rd;
	logic        hwr;
	logic        lwr;
	logic [15:0] data_in;

	modport decode (
		output sel_tfr, sel_fifo, sel_status, sel_command, sel_intreq, sel_intena,
		output sel_gayleid, tfr_index, rd, hwr, lwr, data_in
	);

	modport user (
		input sel_tfr, sel_fifo, sel_status, sel_command, sel_intreq, sel_intena,
		input sel_gayleid, tfr_index, rd, hwr, lwr, data_in
	);
endinterface

`default_nettype wire

//--- verilog/ide_bus_decode.sv
/*
 * CPU address decoder for the IDE and Gayle windows.
 * Purely combinational, results travel on the ide_sel_if bus.
 */
`default_nettype none
`include "gayle_ide_config.svh"

module ide_bus_decode
	import gayle_ide_pkg::*;
(
	input  logic                   clk,
	input  logic [`IDE_ADDR_W:1]   address_in,
	input  logic                   rd,
	input  logic                   hwr,
	input  logic                   lwr,
	input  logic [15:0]            data_in,
	input  logic                   sel_ide,
	input  logic                   sel_gayle,
	ide_sel_if.decode              bus
);
	logic [3:0] win;

	assign win = address_in[`IDE_WIN_MSB:`IDE_WIN_LSB];

	// task file at $DA0xxx and $DA2xxx without the chip select 2 windows
	assign bus.sel_tfr = sel_ide && win[3:2] == 2'b00 && !win[0];
	assign bus.tfr_index = ide_reg_e'(address_in[`IDE_REG_MSB:`IDE_REG_LSB]);
	assign bus.sel_fifo = bus.sel_tfr && bus.tfr_index == REG_DATA;
	// index 7 reads status and writes command
	assign bus.sel_status = rd && bus.sel_tfr && bus.tfr_index == REG_STATUS;
	assign bus.sel_command = hwr && bus.sel_tfr && bus.tfr_index == REG_STATUS;
	// intreq change register at $DA9xxx, intena at $DAAxxx
	assign bus.sel_intreq = sel_ide && win == 4'b1001;
	assign bus.sel_intena = sel_ide && win == 4'b1010;
	// gayle id at $DE1xxx
	assign bus.sel_gayleid = sel_gayle && win == 4'b0001;

	assign bus.rd = rd;
	assign bus.hwr = hwr;
	assign bus.lwr = lwr;
	assign bus.data_in = data_in;

	// the $DAxxxx and $DExxxx chip selects never hit together
	a_one_window: assert property (@(posedge clk)
		$onehot0({sel_ide, sel_gayle}));

endmodule

`default_nettype wire

//--- verilog/ide_task_file.sv
/*
 * ATA task file, eight byte registers plus the drive select bit.
 * The CPU owns it while idle, the host while a command is busy.
 */
`default_nettype none

module ide_task_file
	import gayle_ide_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	ide_sel_if.user     bus,
	input  logic        busy,
	input  ide_reg_e    hdd_addr,
	input  logic [15:0] hdd_data_out,
	input  logic        hdd_wr,
	output logic [7:0]  tfr_out,
	output logic        dev
);
	logic [7:0] tfr [8];
	ide_reg_e   tfr_sel;
	logic [7:0] tfr_in;
	logic       tfr_we;

	// cpu uses the high byte lane and the host the low one
	assign tfr_we = busy ? hdd_wr : bus.sel_tfr && bus.hwr;
	assign tfr_sel = busy ? hdd_addr : bus.tfr_index;
	assign tfr_in = busy ? hdd_data_out[7:0] : bus.data_in[15:8];

	always_ff @(posedge clk) begin
		if (tfr_we)
			tfr[tfr_sel] <= tfr_in;
	end

	assign tfr_out = tfr[tfr_sel];

	// drive select is bit 4 of device/head
	always_ff @(posedge clk) begin
		if (reset)
			dev <= 1'b0;
		else if (tfr_we && tfr_sel == REG_DEVHEAD)
			dev <= tfr_in[4];
	end

endmodule

`default_nettype wire

//--- verilog/ide_command_ctrl.sv
/*
 * Command state for the IDE bridge.
 * Tracks busy, PIO direction, error and interrupts, builds the status byte
 * and steers the sector buffer between CPU and host.
 */
`default_nettype none

module ide_command_ctrl
	import gayle_ide_pkg::*;
(
	input  logic        clk,
	input  logic        reset,
	ide_sel_if.user     bus,
	input  logic        hdd_status_wr,
	input  logic        hdd_data_wr,
	input  logic        hdd_data_rd,
	input  logic [15:0] hdd_data_out,
	input  logic        fifo_empty,
	output logic        busy,
	output ide_status_t status,
	output logic        intena,
	output logic        intreq,
	output logic        fifo_clear,
	output logic        fifo_wr,
	output logic        fifo_rd,
	output logic [15:0] fifo_wdata,
	output logic        hdd_cmd_req,
	output logic        hdd_dat_req
);
	host_status_t hs;
	logic         host_wr;
	logic         pio_in;
	logic         pio_out;
	logic         error;
	logic         bsy;
	logic         drq;
	logic         drdy;

	assign hs = host_status_t'(hdd_data_out[7:0]);
	// host status writes only count while a command is running
	assign host_wr = busy && hdd_status_wr;

	always_ff @(posedge clk) begin
		if (reset) begin
			busy <= 1'b0;
			pio_in <= 1'b0;
			pio_out <= 1'b0;
			error <= 1'b0;
			intena <= 1'b0;
			intreq <= 1'b0;
		end else begin
			// done bit releases the task file back to the cpu
			if (host_wr && hs.done)
				busy <= 1'b0;
			else if (bus.sel_command)
				busy <= 1'b1;
			// pio in stays until the cpu has drained the buffer
			if (drdy)
				pio_in <= 1'b0;
			else if (host_wr && hs.pio_in)
				pio_in <= 1'b1;
			if (host_wr && hs.done)
				pio_out <= 1'b0;
			else if (host_wr && hs.pio_out)
				pio_out <= 1'b1;
			// error sticks until the next command
			if (bus.sel_command)
				error <= 1'b0;
			else if (host_wr && hs.error)
				error <= 1'b1;
			if (bus.sel_intena && bus.hwr)
				intena <= bus.data_in[15];
			// writing zero to bit 15 acks the request
			if (host_wr && hs.intrq && intena)
				intreq <= 1'b1;
			else if (bus.sel_intreq && bus.hwr && !bus.data_in[15])
				intreq <= 1'b0;
		end
	end

	assign drq = (pio_in && !fifo_empty) || (pio_out && fifo_empty);
	assign bsy = busy && !drq;
	assign drdy = !(bsy || drq);
	assign status = '{bsy: bsy, drdy: drdy, drq: drq, err: error, default: '0};

	assign hdd_cmd_req = bsy;
	assign hdd_dat_req = pio_out && !fifo_empty;

	// pio in fills from the host, otherwise from the cpu
	assign fifo_clear = reset || bus.sel_command;
	assign fifo_wdata = pio_in ? hdd_data_out : bus.data_in;
	assign fifo_wr = pio_in ? hdd_data_wr : bus.sel_fifo && bus.hwr && bus.lwr;
	assign fifo_rd = pio_out ? hdd_data_rd : bus.sel_fifo && bus.rd;

	a_one_direction: assert property (@(posedge clk) disable iff (reset)
		host_wr |=> !(pio_in && pio_out));

endmodule

`default_nettype wire

//--- verilog/sector_fifo.sv
/*
 * Sector data buffer, 256 words of 16 bits.
 * Registered head word, empty flag follows the pointers one cycle late.
 */
`default_nettype none
`include "gayle_ide_config.svh"

module sector_fifo (
	input  logic        clk,
	input  logic        clear,
	input  logic        wr,
	input  logic        rd,
	input  logic [15:0] wdata,
	output logic [15:0] rdata,
	output logic        full,
	output logic        empty
);
	logic [15:0]           mem [`IDE_FIFO_DEPTH];
	// extra msb is the wrap bit
	logic [`IDE_FIFO_AW:0] wr_ptr;
	logic [`IDE_FIFO_AW:0] rd_ptr;
	logic [`IDE_FIFO_AW:0] fill;
	logic                  ptr_equal;

	assign ptr_equal = wr_ptr == rd_ptr;
	assign full = wr_ptr[`IDE_FIFO_AW] != rd_ptr[`IDE_FIFO_AW] &&
		wr_ptr[`IDE_FIFO_AW-1:0] == rd_ptr[`IDE_FIFO_AW-1:0];
	assign fill = wr_ptr - rd_ptr;

	always_ff @(posedge clk) begin
		if (wr && !full)
			mem[wr_ptr[`IDE_FIFO_AW-1:0]] <= wdata;
		rdata <= mem[rd_ptr[`IDE_FIFO_AW-1:0]];
	end

	// reads are gated on the live pointer compare, not the late flag
	always_ff @(posedge clk) begin
		if (clear) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			empty <= 1'b1;
		end else begin
			if (wr && !full)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd && !ptr_equal)
				rd_ptr <= rd_ptr + 1'b1;
			empty <= ptr_equal;
		end
	end

	a_fill_range: assert property (@(posedge clk) disable iff (clear)
		fill <= `IDE_FIFO_DEPTH);

endmodule

`default_nettype wire

//--- verilog/ide_register_read.sv
/*
 * CPU read data for the IDE and Gayle windows.
 * Also steps the Gayle ID sequence on each ID read.
 */
`default_nettype none

module ide_register_read
	import gayle_ide_pkg::*;
(
	input  logic        clk,
	ide_sel_if.user     bus,
	input  logic [7:0]  tfr_out,
	input  logic [15:0] fifo_rdata,
	input  ide_status_t status,
	input  logic        dev,
	input  logic [1:0]  hdd_ena,
	input  logic        intena,
	input  logic        intreq,
	output logic [15:0] data_out
);
	logic [1:0] id_cnt;
	logic       drive_on;

	// id msb reads 1, 1, 0, 1
	always_ff @(posedge clk) begin
		if (bus.sel_gayleid && bus.hwr)
			id_cnt <= 2'd0;
		else if (bus.sel_gayleid && bus.rd)
			id_cnt <= id_cnt + 2'd1;
	end

	assign drive_on = dev ? hdd_ena[1] : hdd_ena[0];

	always_comb begin
		data_out = '0;
		if (bus.sel_fifo && bus.rd)
			data_out = fifo_rdata;
		else if (bus.sel_status)
			data_out = drive_on ? {status, 8'h00} : 16'h0000;
		else if (bus.sel_tfr && bus.rd)
			data_out = {tfr_out, 8'h00};
		// single bit registers land on bit 15
		if (bus.rd) begin
			data_out[15] |= bus.sel_intreq && intreq;
			data_out[15] |= bus.sel_intena && intena;
			data_out[15] |= bus.sel_gayleid && id_cnt != 2'b10;
		end
	end

endmodule

`default_nettype wire

//--- verilog/gayle_ide.sv
/*
 * Gayle IDE bridge top level.
 * Plain CPU bus and host ports; the host services each ATA command.
 */
`default_nettype none
`include "gayle_ide_config.svh"

module gayle_ide
	import gayle_ide_pkg::*;
(
	input  logic                 clk,
	input  logic                 reset,
	input  logic [`IDE_ADDR_W:1] address_in,
	input  logic [15:0]          data_in,
	output logic [15:0]          data_out,
	input  logic                 rd,
	input  logic                 hwr,
	input  logic                 lwr,
	// $DAxxxx and $DExxxx chip selects
	input  logic                 sel_ide,
	input  logic                 sel_gayle,
	output logic                 irq,
	// master and slave enables
	input  logic [1:0]           hdd_ena,
	output logic                 hdd_cmd_req,
	output logic                 hdd_dat_req,
	input  logic [2:0]           hdd_addr,
	input  logic [15:0]          hdd_data_out,
	output logic [15:0]          hdd_data_in,
	input  logic                 hdd_wr,
	input  logic                 hdd_status_wr,
	input  logic                 hdd_data_wr,
	input  logic                 hdd_data_rd
);
	ide_sel_if   sel_bus ();
	ide_reg_e    host_reg;
	logic        busy;
	ide_status_t status;
	logic        intena;
	logic        intreq;
	logic        dev;
	logic [7:0]  tfr_out;
	logic        fifo_clear;
	logic        fifo_wr;
	logic        fifo_rd;
	logic        fifo_empty;
	logic [15:0] fifo_wdata;
	logic [15:0] fifo_rdata;

	assign host_reg = ide_reg_e'(hdd_addr);
	assign irq = intreq;
	// data register reads the buffer head, the rest the task file
	assign hdd_data_in = host_reg == REG_DATA ? fifo_rdata : {8'h00, tfr_out};

	ide_bus_decode u_decode (
		.clk, .address_in, .rd, .hwr, .lwr, .data_in, .sel_ide, .sel_gayle,
		.bus(sel_bus.decode)
	);

	ide_task_file u_task_file (
		.clk, .reset, .bus(sel_bus.user), .busy, .hdd_addr(host_reg), .hdd_data_out,
		.hdd_wr, .tfr_out, .dev
	);

	ide_command_ctrl u_command (
		.clk, .reset, .bus(sel_bus.user), .hdd_status_wr, .hdd_data_wr, .hdd_data_rd,
		.hdd_data_out, .fifo_empty, .busy, .status, .intena, .intreq, .fifo_clear,
		.fifo_wr, .fifo_rd, .fifo_wdata, .hdd_cmd_req, .hdd_dat_req
	);

	sector_fifo u_fifo (
		.clk, .clear(fifo_clear), .wr(fifo_wr), .rd(fifo_rd), .wdata(fifo_wdata),
		.rdata(fifo_rdata), .full(), .empty(fifo_empty)
	);

	ide_register_read u_read (
		.clk, .bus(sel_bus.user), .tfr_out, .fifo_rdata, .status, .dev, .hdd_ena,
		.intena, .intreq, .data_out
	);

endmodule

`default_nettype wire

//--- test/tb_clock.sv
/*
 * Free running clock for the testbench.
 * Starts low and toggles every half period.
 */
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100
) (
	output logic clk
);
	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end
endmodule

`default_nettype wire

//--- test/gayle_ide_tb.sv
/*
 * Testbench for the Gayle IDE bridge.
 * Random CPU and host traffic from a fixed seed, checked against a model of
 * the task file, command state, sector buffer, interrupts and the ID sequence.
 */
`default_nettype none
`include "gayle_ide_config.svh"

module gayle_ide_tb
	import gayle_ide_pkg::*;
();
	localparam int DRIVE_DELAY = 10;
	localparam int SAMPLE_DELAY = 40;
	localparam int MAX_POLLS = 20;
	// gayle id msb in read order after a restart, first read in the top bit
	localparam logic [3:0] ID_SEQ = 4'b1101;

	logic                 clk;
	logic                 reset;
	logic [`IDE_ADDR_W:1] address_in;
	logic [15:0]          data_in;
	logic [15:0]          data_out;
	logic                 rd, hwr, lwr, sel_ide, sel_gayle, irq;
	logic [1:0]           hdd_ena;
	logic                 hdd_cmd_req, hdd_dat_req;
	logic [2:0]           hdd_addr;
	logic [15:0]          hdd_data_out, hdd_data_in;
	logic                 hdd_wr, hdd_status_wr, hdd_data_wr, hdd_data_rd;

	// reference model state
	logic [7:0]  m_tfr [8];
	logic        m_busy, m_pio_in, m_pio_out, m_err, m_intena, m_intreq, m_dev;
	logic [1:0]  m_id;
	logic [15:0] m_fifo [$];
	logic [31:0] rng_state;
	// request lines captured in the last host cycle
	logic        s_cmd_req, s_dat_req;

	tb_clock #(.PERIOD(100)) u_clock (.clk);

	gayle_ide DUT (.*);

	function automatic logic [31:0] xorshift32();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// byte address from base, window nibble and register index at bits 4:2
	function automatic logic [`IDE_ADDR_W:1] bus_addr(input logic [7:0] base,
			input logic [3:0] win, input logic [2:0] idx);
		logic [23:0] byte_addr;
		byte_addr = {base, win, 7'd0, idx, 2'd0};
		return byte_addr[23:1];
	endfunction

	// DRQ by direction and fill, BSY when busy without DRQ
	function automatic ide_status_t model_status();
		ide_status_t s;
		logic        drq;
		drq = (m_pio_in && m_fifo.size() != 0) || (m_pio_out && m_fifo.size() == 0);
		s = '0;
		s.drq = drq;
		s.bsy = m_busy && !drq;
		s.drdy = !s.bsy && !drq;
		s.err = m_err;
		return s;
	endfunction

	function automatic logic drive_enabled();
		return m_dev ? hdd_ena[1] : hdd_ena[0];
	endfunction

	task automatic fail_run(input string why);
		$display("Error: at time %0t, %s", $time, why);
		$display("Simulation failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_word(input string name, input logic [15:0] got,
			input logic [15:0] exp);
		if (got !== exp) begin
			$display("Error: at time %0t, %s is %h, expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "word mismatch");
		end
	endtask

	task automatic check_status(input string name, input ide_status_t got,
			input ide_status_t exp);
		if (got !== exp) begin
			$display("Error: at time %0t, %s is %h, expected %h", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "status mismatch");
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("Error: at time %0t, %s is %b, expected %b", $time, name, got, exp);
			$display("Simulation failed");
			$fatal(1, "bit mismatch");
		end
	endtask

	// one strobe cycle then one idle cycle, so the buffer head can refill
	task automatic cpu_cycle(input logic gayle, input logic [3:0] win, input logic [2:0] idx,
			input logic is_rd, input logic [15:0] wdata, output logic [15:0] rdata);
		@(posedge clk);
		#DRIVE_DELAY;
		address_in = bus_addr(gayle ? 8'hDE : 8'hDA, win, idx);
		sel_ide = !gayle;
		sel_gayle = gayle;
		data_in = wdata;
		rd = is_rd;
		hwr = !is_rd;
		lwr = !is_rd;
		#SAMPLE_DELAY;
		rdata = data_out;
		@(posedge clk);
		#DRIVE_DELAY;
		sel_ide = 1'b0;
		sel_gayle = 1'b0;
		rd = 1'b0;
		hwr = 1'b0;
		lwr = 1'b0;
	endtask

	task automatic cpu_write(input logic gayle, input logic [3:0] win, input logic [2:0] idx,
			input logic [15:0] wdata);
		logic [15:0] unused;
		cpu_cycle(gayle, win, idx, 1'b0, wdata, unused);
	endtask

	task automatic cpu_read(input logic gayle, input logic [3:0] win, input logic [2:0] idx,
			output logic [15:0] rdata);
		cpu_cycle(gayle, win, idx, 1'b1, 16'h0000, rdata);
	endtask

	// strobes are {hdd_wr, hdd_status_wr, hdd_data_wr, hdd_data_rd}
	task automatic host_cycle(input logic [2:0] addr, input logic [15:0] wdata,
			input logic [3:0] strobes, output logic [15:0] rdata);
		@(posedge clk);
		#DRIVE_DELAY;
		hdd_addr = addr;
		hdd_data_out = wdata;
		{hdd_wr, hdd_status_wr, hdd_data_wr, hdd_data_rd} = strobes;
		#SAMPLE_DELAY;
		rdata = hdd_data_in;
		s_cmd_req = hdd_cmd_req;
		s_dat_req = hdd_dat_req;
		@(posedge clk);
		#DRIVE_DELAY;
		{hdd_wr, hdd_status_wr, hdd_data_wr, hdd_data_rd} = 4'b0000;
	endtask

	// pio in drops once the status reads ready
	task automatic settle_model();
		ide_status_t st;
		st = model_status();
		if (st.drdy)
			m_pio_in = 1'b0;
	endtask

	task automatic tfr_write(input logic [2:0] idx, input logic [7:0] value);
		cpu_write(1'b0, 4'h2, idx, {value, 8'h00});
		m_tfr[idx] = value;
		if (idx == REG_DEVHEAD)
			m_dev = value[4];
	endtask

	// command write starts busy, clears error and empties the buffer
	task automatic command_write(input logic [7:0] cmd);
		tfr_write(REG_STATUS, cmd);
		m_busy = 1'b1;
		m_err = 1'b0;
		m_fifo.delete();
	endtask

	task automatic host_status(input logic [7:0] value);
		logic [15:0] unused;
		host_cycle(3'd0, {8'h00, value}, 4'b0100, unused);
		// only counts while a command is running
		if (m_busy) begin
			if (value[4] && m_intena)
				m_intreq = 1'b1;
			if (value[0])
				m_err = 1'b1;
			if (value[3])
				m_pio_in = 1'b1;
			if (value[7]) begin
				m_busy = 1'b0;
				m_pio_out = 1'b0;
			end else if (value[2]) begin
				m_pio_out = 1'b1;
			end
		end
		settle_model();
	endtask

	// status reads zero when the selected drive is off
	task automatic status_check();
		logic [15:0] d;
		cpu_read(1'b0, 4'h2, REG_STATUS, d);
		if (drive_enabled())
			check_status("data_out status", ide_status_t'(d[15:8]), model_status());
		else
			check_word("data_out gated status", d, 16'h0000);
	endtask

	task automatic wait_drq(input logic want);
		logic [15:0] d;
		ide_status_t st;
		int          polls;
		cpu_read(1'b0, 4'h2, REG_STATUS, d);
		st = ide_status_t'(d[15:8]);
		polls = 1;
		while (st.drq !== want && polls < MAX_POLLS) begin
			cpu_read(1'b0, 4'h2, REG_STATUS, d);
			st = ide_status_t'(d[15:8]);
			polls++;
		end
		if (st.drq !== want)
			fail_run("status DRQ did not change within the poll limit");
	endtask

	task automatic wait_dat_req(input logic want);
		int cycles;
		cycles = 0;
		while (hdd_dat_req !== want && cycles < MAX_POLLS) begin
			@(posedge clk);
			#(DRIVE_DELAY + SAMPLE_DELAY);
			cycles++;
		end
		if (hdd_dat_req !== want)
			fail_run("hdd_dat_req did not settle within the cycle limit");
	endtask

	initial begin
		logic [15:0] d;
		logic [15:0] w;
		logic [7:0]  b;
		ide_status_t st;
		int          n;

		rng_state = 32'd776;
		reset = 1'b1;
		address_in = '0;
		data_in = '0;
		{rd, hwr, lwr, sel_ide, sel_gayle} = '0;
		hdd_ena = 2'b11;
		hdd_addr = '0;
		hdd_data_out = '0;
		{hdd_wr, hdd_status_wr, hdd_data_wr, hdd_data_rd} = '0;
		{m_busy, m_pio_in, m_pio_out, m_err, m_intena, m_intreq, m_dev} = '0;
		m_id = '0;
		for (int i = 0; i < 8; i++)
			m_tfr[i] = 8'h00;

		repeat (16) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		check_bit("irq", irq, 1'b0);
		check_bit("hdd_cmd_req", hdd_cmd_req, 1'b0);
		check_bit("hdd_dat_req", hdd_dat_req, 1'b0);

		// task file round trip through the high byte lane
		for (int i = 1; i <= 6; i++)
			tfr_write(3'(i), 8'(xorshift32()));
		for (int i = 1; i <= 6; i++) begin
			cpu_read(1'b0, 4'h2, 3'(i), d);
			check_word("data_out task file", d, {m_tfr[i], 8'h00});
		end
		status_check();

		// command where the host reads the task file and ends with an error
		command_write(8'(xorshift32()));
		status_check();
		for (int i = 1; i <= 7; i++) begin
			host_cycle(3'(i), 16'h0000, 4'b0000, d);
			st = model_status();
			check_word("hdd_data_in task file", d, {8'h00, m_tfr[i]});
			check_bit("hdd_cmd_req", s_cmd_req, st.bsy);
		end
		b = 8'(xorshift32());
		host_cycle(REG_ERROR, {8'h00, b}, 4'b1000, d);
		m_tfr[REG_ERROR] = b;
		host_status(8'h81);
		status_check();
		cpu_read(1'b0, 4'h2, REG_ERROR, d);
		check_word("data_out error register", d, {m_tfr[REG_ERROR], 8'h00});

		// pio in where the host fills and the cpu drains
		command_write(8'(xorshift32()));
		status_check();
		host_status(8'h08);
		n = int'(xorshift32() % 256) + 1;
		repeat (n) begin
			w = 16'(xorshift32());
			host_cycle(REG_DATA, w, 4'b0010, d);
			m_fifo.push_back(w);
		end
		wait_drq(1'b1);
		status_check();
		host_status(8'h80);
		status_check();
		while (m_fifo.size() != 0) begin
			cpu_read(1'b0, 4'h2, REG_DATA, d);
			check_word("data_out sector word", d, m_fifo.pop_front());
			settle_model();
		end
		wait_drq(1'b0);
		status_check();

		// pio out where the cpu fills and the host drains
		command_write(8'(xorshift32()));
		host_status(8'h04);
		status_check();
		n = int'(xorshift32() % 256) + 1;
		repeat (n) begin
			w = 16'(xorshift32());
			cpu_write(1'b0, 4'h2, REG_DATA, w);
			m_fifo.push_back(w);
		end
		while (m_fifo.size() != 0) begin
			host_cycle(REG_DATA, 16'h0000, 4'b0001, d);
			check_bit("hdd_dat_req", s_dat_req, 1'b1);
			check_word("hdd_data_in sector word", d, m_fifo.pop_front());
		end
		wait_dat_req(1'b0);
		host_status(8'h80);
		status_check();

		// interrupt with intena off, then on
		for (int k = 0; k < 2; k++) begin
			m_intena = k[0];
			cpu_write(1'b0, 4'hA, 3'd0, {m_intena, 15'd0});
			command_write(8'(xorshift32()));
			host_status(8'h90);
			#SAMPLE_DELAY;
			check_bit("irq", irq, m_intreq);
			cpu_read(1'b0, 4'h9, 3'd0, d);
			check_word("data_out intreq", d, {m_intreq, 15'd0});
			cpu_read(1'b0, 4'hA, 3'd0, d);
			check_word("data_out intena", d, {m_intena, 15'd0});
			// zero in bit 15 acks the request
			cpu_write(1'b0, 4'h9, 3'd0, 16'h0000);
			m_intreq = 1'b0;
			#SAMPLE_DELAY;
			check_bit("irq", irq, m_intreq);
			cpu_read(1'b0, 4'h9, 3'd0, d);
			check_word("data_out intreq", d, {m_intreq, 15'd0});
		end

		// gayle id sequence restarts on a write
		cpu_write(1'b1, 4'h1, 3'd0, 16'h0000);
		m_id = 2'd0;
		repeat (4) begin
			cpu_read(1'b1, 4'h1, 3'd0, d);
			check_word("data_out gayle id", d, {ID_SEQ[3 - m_id], 15'd0});
			m_id++;
		end

		// random drive enables against the drive select bit
		repeat (8) begin
			hdd_ena = 2'(xorshift32());
			tfr_write(REG_DEVHEAD, 8'(xorshift32()));
			status_check();
		end

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

`default_nettype wire

//--- gayle_ide.f
+incdir+verilog
verilog/gayle_ide_pkg.sv
verilog/ide_sel_if.sv
verilog/ide_bus_decode.sv
verilog/ide_task_file.sv
verilog/ide_command_ctrl.sv
verilog/sector_fifo.sv
verilog/ide_register_read.sv
verilog/gayle_ide.sv
test/tb_clock.sv
test/gayle_ide_tb.sv

//--- Bender.yml
package:
  name: gayle_ide

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/gayle_ide_pkg.sv
      - verilog/ide_sel_if.sv
      - verilog/ide_bus_decode.sv
      - verilog/ide_task_file.sv
      - verilog/ide_command_ctrl.sv
      - verilog/sector_fifo.sv
      - verilog/ide_register_read.sv
      - verilog/gayle_ide.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_clock.sv
      - test/gayle_ide_tb.sv
